// File: design/rv_isa_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I subset constants shared by the core and the testbench
// only the opcodes the core executes are named here, all others halt
// alu_op_t is {instr[30], funct3} so R-type ops map onto it directly
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_isa_pkg;

	localparam int xlen       = 32; // data and address width
	localparam int reg_addr_w = 5;
	localparam int reg_count  = 32;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu operations
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000, // bit 30 set
		alu_sra  = 4'b1101  // bit 30 set
	} alu_op_t;

endpackage

// File: design/core_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control types of the multicycle core
// one phase register, all selects driven from core_fsm
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_ctrl_pkg;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_exec,
		ph_mem,
		ph_wb,
		ph_halt // undefined opcode, no bus activity ever again
	} phase_t;

	// next program counter source
	typedef enum logic [1:0] {
		pc_plus4,
		pc_branch,   // delayed target in alu_out2
		pc_jump,     // alu_out
		pc_jump_clr  // alu_out with bit 0 cleared, jalr
	} pc_sel_t;

	typedef enum logic {addr_pc, addr_alu} addr_sel_t;

	typedef enum logic {srca_reg, srca_pc} srca_sel_t;

	typedef enum logic {srcb_reg, srcb_imm} srcb_sel_t;

	// register write source
	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_pc,   // pc already advanced by 4
		wb_load
	} wb_sel_t;

endpackage

// File: design/core_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phase sequencer of the multicycle core, outputs are combinational
// rd and we are held until ready, the bus may stall indefinitely
// any opcode outside the kept subset ends in ph_halt for good
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module core_fsm
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic [xlen-1:0] instr,
	input  logic            ready,
	input  logic            branch_taken,
	output logic            rd,
	output logic            we,
	output logic            ir_write,
	output logic            pc_write,
	output logic            reg_write,
	output pc_sel_t         pc_sel,
	output addr_sel_t       addr_sel,
	output srca_sel_t       srca_sel,
	output srcb_sel_t       srcb_sel,
	output alu_op_t         alu_op,
	output wb_sel_t         wb_sel
);

	phase_t  phase;
	phase_t  phase_n;
	opcode_t opcode;
	logic [2:0] funct3;
	alu_op_t exec_op;
	logic    use_imm;

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];

	always_ff @(posedge clk) begin
		if (rst)
			phase <= ph_fetch;
		else
			phase <= phase_n;
	end

	// alu op for exec, mem and wb
	always_comb begin
		case (opcode)
			op_reg:    exec_op = alu_op_t'({instr[30], funct3});
			op_imm:    exec_op = alu_op_t'({instr[30] & (funct3 == 3'b101), funct3}); // srai only
			op_branch: exec_op = funct3[2] ? alu_op_t'({2'b00, funct3[2:1]}) : alu_sub;
			default:   exec_op = alu_add; // address and jalr target
		endcase
	end

	assign use_imm = (opcode == op_imm) || (opcode == op_load) ||
		(opcode == op_store) || (opcode == op_jalr);

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next phase and datapath controls
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		phase_n   = phase;
		rd        = 1'b0;
		we        = 1'b0;
		ir_write  = 1'b0;
		pc_write  = 1'b0;
		reg_write = 1'b0;
		pc_sel    = pc_plus4;
		addr_sel  = addr_pc;
		srca_sel  = srca_reg;
		srcb_sel  = use_imm ? srcb_imm : srcb_reg; // held steady through mem
		alu_op    = exec_op;
		wb_sel    = wb_alu;
		case (phase)
			ph_fetch: begin
				rd       = 1'b1;
				ir_write = ready;
				if (ready)
					phase_n = ph_decode;
			end
			ph_decode: begin
				pc_write = 1'b1; // pc + 4
				srca_sel = srca_pc; // old pc + imm into alu_out
				srcb_sel = srcb_imm;
				alu_op   = alu_add;
				case (opcode)
					op_lui, op_auipc, op_jal:
						phase_n = ph_wb;
					op_jalr, op_branch, op_load, op_store, op_imm, op_reg:
						phase_n = ph_exec;
					default:
						phase_n = ph_halt;
				endcase
			end
			ph_exec: begin
				if (opcode == op_load || opcode == op_store)
					phase_n = ph_mem;
				else
					phase_n = ph_wb;
			end
			ph_mem: begin
				addr_sel = addr_alu;
				rd = (opcode == op_load);
				we = (opcode == op_store);
				if (ready)
					phase_n = (opcode == op_load) ? ph_wb : ph_fetch;
			end
			ph_wb: begin
				phase_n   = ph_fetch;
				reg_write = 1'b1;
				case (opcode)
					op_lui:  wb_sel = wb_imm;
					op_load: wb_sel = wb_load;
					op_jal: begin
						wb_sel   = wb_pc;
						pc_write = 1'b1;
						pc_sel   = pc_jump;
					end
					op_jalr: begin
						wb_sel   = wb_pc;
						pc_write = 1'b1;
						pc_sel   = pc_jump_clr;
					end
					op_branch: begin
						reg_write = 1'b0;
						pc_write  = branch_taken;
						pc_sel    = pc_branch;
					end
					default: wb_sel = wb_alu; // op, op-imm, auipc
				endcase
			end
			default: phase_n = ph_halt; // halted, stays here
		endcase
	end

endmodule

// File: design/pc_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, loads start_addr at reset
// no alignment check on jump targets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pc_unit
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;
#(
	parameter logic [xlen-1:0] start_addr = '0
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            pc_write,
	input  pc_sel_t         pc_sel,
	input  logic [xlen-1:0] alu_out,
	input  logic [xlen-1:0] alu_out2,
	output logic [xlen-1:0] pc
);

	logic [xlen-1:0] pc_next;

	always_comb begin
		case (pc_sel)
			pc_plus4:    pc_next = pc + xlen'(4);
			pc_branch:   pc_next = alu_out2; // target from decode
			pc_jump:     pc_next = alu_out;
			pc_jump_clr: pc_next = {alu_out[xlen-1:1], 1'b0};
			default:     pc_next = pc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= start_addr;
		else if (pc_write)
			pc <= pc_next;
	end

endmodule

// File: design/reg_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file, async read, write on clock edge
// x0 reads zero, writes to it are dropped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module reg_file
	import rv_isa_pkg::*;
(
	input  logic                  clk,
	input  logic [reg_addr_w-1:0] ra0,
	input  logic [reg_addr_w-1:0] ra1,
	input  logic [reg_addr_w-1:0] wa,
	input  logic                  we,
	input  logic [xlen-1:0]       wd,
	output logic [xlen-1:0]       rd0,
	output logic [xlen-1:0]       rd1
);

	logic [xlen-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

// File: design/alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational ALU, ten RV32I operations
// shift amount is b[4:0], unknown op codes give zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu
	import rv_isa_pkg::*;
(
	input  alu_op_t         op,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	output logic [xlen-1:0] y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_add:  y = a + b;
			alu_sub:  y = a - b; // also beq/bne compare
			alu_sll:  y = a << shamt;
			alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
			alu_xor:  y = a ^ b;
			alu_srl:  y = a >> shamt;
			alu_sra:  y = $signed(a) >>> shamt;
			alu_or:   y = a | b;
			alu_and:  y = a & b;
			default:  y = '0;
		endcase
	end

endmodule

// File: design/imm_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// immediate extraction, format picked from the opcode
// all formats sign extended, unknown opcodes give zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module imm_decode
	import rv_isa_pkg::*;
(
	input  logic [xlen-1:0] instr,
	output logic [xlen-1:0] imm
);

	opcode_t opcode;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	assign opcode = opcode_t'(instr[6:0]);

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opcode)
			op_lui, op_auipc:         imm = imm_u;
			op_imm, op_load, op_jalr: imm = imm_i;
			op_branch:                imm = imm_b;
			op_jal:                   imm = imm_j;
			op_store:                 imm = imm_s;
			default:                  imm = '0;
		endcase
	end

endmodule

// File: design/mem_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus side of the core, word addresses only
// bus words are byte reversed against register values in both ways
// a data address is held in mar while the request waits for ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_port
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic            clk,
	input  addr_sel_t       addr_sel,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] alu_out,
	input  logic [xlen-1:0] store_data,
	input  logic [xlen-1:0] spo,
	output logic [xlen-1:0] a,
	output logic [xlen-1:0] d,
	output logic [xlen-1:0] load_data,
	output logic [xlen-1:0] fetch_word
);

	addr_sel_t       sel_q; // addr_sel of the last cycle
	logic [xlen-1:0] sel_addr;
	logic [xlen-1:0] mar;
	logic [xlen-1:0] mdr;

	always_comb begin
		if (addr_sel == addr_pc)
			sel_addr = pc;
		else if (sel_q == addr_alu)
			sel_addr = mar; // data request still waiting
		else
			sel_addr = alu_out;
	end

	assign a = {sel_addr[xlen-1:2], 2'b00};

	assign d = {store_data[7:0], store_data[15:8], store_data[23:16], store_data[31:24]};
	assign fetch_word = {spo[7:0], spo[15:8], spo[23:16], spo[31:24]};

	always_ff @(posedge clk) begin
		sel_q <= addr_sel;
		mar   <= a;
		mdr   <= fetch_word; // holds the ready-cycle word in wb
	end

	assign load_data = mdr;

endmodule

// File: design/rv_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multicycle RV32I subset core, one instruction in flight
// no M, no CSRs, no interrupts, only word loads and stores
// start_addr is the first fetch address after reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rv_core
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;
#(
	parameter logic [xlen-1:0] start_addr = '0
)
(
	input  logic            clk,
	input  logic            rst,
	output logic [xlen-1:0] a,
	output logic [xlen-1:0] d,
	output logic            we,
	output logic            rd,
	input  logic [xlen-1:0] spo,
	input  logic            ready
);

	logic            ir_write;
	logic            pc_write;
	logic            reg_write;
	logic            branch_taken;
	pc_sel_t         pc_sel;
	addr_sel_t       addr_sel;
	srca_sel_t       srca_sel;
	srcb_sel_t       srcb_sel;
	alu_op_t         alu_op;
	wb_sel_t         wb_sel;
	logic [xlen-1:0] instr;
	logic [xlen-1:0] fetch_word;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rd0;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] reg_a;
	logic [xlen-1:0] reg_b;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] alu_out2;
	logic [xlen-1:0] wb_data;
	logic [2:0]      funct3;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath registers
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (ir_write)
			instr <= fetch_word;
		reg_a    <= rd0;
		reg_b    <= rd1;
		alu_out  <= alu_result;
		alu_out2 <= alu_out; // keeps the branch target from decode
	end

	assign alu_a = (srca_sel == srca_pc) ? pc : reg_a;
	assign alu_b = (srcb_sel == srcb_imm) ? imm : reg_b;

	always_comb begin
		case (wb_sel)
			wb_alu:  wb_data = alu_out;
			wb_imm:  wb_data = imm;
			wb_pc:   wb_data = pc; // link address
			default: wb_data = load_data;
		endcase
	end

	// beq bge bgeu want a zero result
	assign funct3 = instr[14:12];
	assign branch_taken = (funct3[2] ? funct3[0] : ~funct3[0]) ^ (|alu_out);

	core_fsm u_core_fsm (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.ready        (ready),
		.branch_taken (branch_taken),
		.rd           (rd),
		.we           (we),
		.ir_write     (ir_write),
		.pc_write     (pc_write),
		.reg_write    (reg_write),
		.pc_sel       (pc_sel),
		.addr_sel     (addr_sel),
		.srca_sel     (srca_sel),
		.srcb_sel     (srcb_sel),
		.alu_op       (alu_op),
		.wb_sel       (wb_sel)
	);

	pc_unit #(.start_addr(start_addr)) u_pc_unit (
		.clk      (clk),
		.rst      (rst),
		.pc_write (pc_write),
		.pc_sel   (pc_sel),
		.alu_out  (alu_out),
		.alu_out2 (alu_out2),
		.pc       (pc)
	);

	reg_file u_reg_file (
		.clk (clk),
		.ra0 (instr[19:15]), // rs1
		.ra1 (instr[24:20]), // rs2
		.wa  (instr[11:7]),
		.we  (reg_write),
		.wd  (wb_data),
		.rd0 (rd0),
		.rd1 (rd1)
	);

	alu u_alu (
		.op (alu_op),
		.a  (alu_a),
		.b  (alu_b),
		.y  (alu_result)
	);

	imm_decode u_imm_decode (
		.instr (instr),
		.imm   (imm)
	);

	mem_port u_mem_port (
		.clk        (clk),
		.addr_sel   (addr_sel),
		.pc         (pc),
		.alu_out    (alu_out),
		.store_data (reg_b),
		.spo        (spo),
		.a          (a),
		.d          (d),
		.load_data  (load_data),
		.fetch_word (fetch_word)
	);

endmodule

// File: tb/core_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus protocol checks on rv_core, bound in from the testbench
// a request holds still until the memory raises ready
// fails counts every failed assertion for the testbench summary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module core_assertions
	import rv_isa_pkg::*;
(
	input logic            clk,
	input logic            rst,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] d,
	input logic            rd,
	input logic            we,
	input logic            ready
);

	int fails = 0;

	// a read and a write never share a cycle
	no_rd_and_we: assert property (@(posedge clk) disable iff (rst) !(rd && we))
		else begin
			$error("rd and we high together");
			fails++;
		end

	held_until_ready: assert property (@(posedge clk) disable iff (rst)
		(rd || we) && !ready |=> $stable(a) && $stable(rd) && $stable(we))
		else begin
			$error("request changed before ready");
			fails++;
		end

	write_data_held: assert property (@(posedge clk) disable iff (rst)
		we && !ready |=> $stable(d)) // d only matters for writes
		else begin
			$error("write data changed before ready");
			fails++;
		end

endmodule

// File: tb/tb_rv_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of rv_core, program is built into memory at time zero
// 256 word memory, bus words byte reversed against register values
// ready comes 0 to 3 cycles after a request is first seen
// program in words 0..243, store slots 244..251, load data 252..255
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_rv_core
	import rv_isa_pkg::*;
();

	localparam int          store_base = 244; // word index, 8 slots
	localparam int          load_base  = 252;
	localparam int          halt_watch = 60;  // cycles watched after halt
	localparam logic [31:0] marker     = 32'h5a5;

	logic        clk;
	logic        rst;
	logic        ready;
	logic        rd;
	logic        we;
	logic [31:0] a;
	logic [31:0] d;
	logic [31:0] spo;
	logic [31:0] mem [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] halt_addr;
	integer      seed = 33;
	int          wait_left = -1;
	int          pc_w = 0;
	int          slot = 0;
	int          errors = 0;
	int          checks = 0;
	longint      limit_ns;
	bit          prog_done = 0;
	bit          halted = 0;

	alu_op_t rr_ops [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and};
	alu_op_t imm_ops [9] = '{alu_add, alu_slt, alu_sltu, alu_xor, alu_or,
		alu_and, alu_sll, alu_srl, alu_sra};
	logic [4:0]  bregs [3] = '{5'd10, 5'd11, 5'd12};
	logic [31:0] bvals [3] = '{32'd7, 32'hffff_fffb, 32'd7};
	logic [2:0]  bf3 [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	int          pr1 [3]   = '{0, 0, 1}; // operand pairs (7,7) (7,-5) (-5,7)
	int          pr2 [3]   = '{2, 1, 0};

	always #20 clk = ~clk;

	rv_core #(.start_addr(32'h0)) u_rv_core (
		.clk   (clk),
		.rst   (rst),
		.a     (a),
		.d     (d),
		.we    (we),
		.rd    (rd),
		.spo   (spo),
		.ready (ready)
	);

	bind rv_core core_assertions u_core_assertions (
		.clk (clk), .rst (rst), .a (a), .d (d), .rd (rd), .we (we), .ready (ready)
	);

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference functions and instruction encoders
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] byte_swap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] x,
		input logic [31:0] y);
		case (op)
			alu_add:  return x + y;
			alu_sub:  return x - y;
			alu_sll:  return x << y[4:0];
			alu_slt:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			alu_sltu: return (x < y) ? 32'd1 : 32'd0;
			alu_xor:  return x ^ y;
			alu_srl:  return x >> y[4:0];
			alu_sra:  return $signed(x) >>> y[4:0];
			alu_or:   return x | y;
			default:  return x & y;
		endcase
	endfunction

	function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'b000:  return x == y;
			3'b001:  return x != y;
			3'b100:  return $signed(x) < $signed(y);
			3'b101:  return $signed(x) >= $signed(y);
			3'b110:  return x < y;
			default: return x >= y; // bgeu
		endcase
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rdx, input opcode_t opc);
		return {imm, rs1, f3, rdx, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store}; // base x0
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rdx,
		input opcode_t opc);
		return {imm, rdx, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rdx);
		return {off[20], off[10:1], off[11], off[19:12], rdx, op_jal};
	endfunction

	task automatic emit(input logic [31:0] w);
		mem[pc_w] = byte_swap(w);
		pc_w++;
	endtask

	// store to the next slot, queued only when the write must happen
	task automatic emit_store(input logic [4:0] rs, input logic [31:0] value,
		input bit expect_it);
		logic [31:0] addr;
		addr = (store_base + slot) * 4;
		slot = (slot + 1) % 8;
		emit(enc_s(addr[11:0], rs));
		if (expect_it) begin
			exp_addr.push_back(addr);
			exp_data.push_back(value);
		end
	endtask

	task automatic load_const(input logic [4:0] rdx, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800; // addi sign extends the low part
		emit(enc_u(hi[31:12], rdx, op_lui));
		emit(enc_i(v[11:0], rdx, 3'b000, rdx, op_imm));
	endtask

	task automatic build_program();
		int          i;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] p;
		logic [11:0] imm;
		logic [19:0] u;
		alu_op_t     op;
		for (i = 0; i < 20; i++) begin
			x = $random(seed);
			y = $random(seed);
			op = rr_ops[i % 10];
			load_const(1, x);
			load_const(2, y);
			emit({1'b0, op[3], 5'b0, 5'd2, 5'd1, op[2:0], 5'd3, op_reg});
			emit_store(3, alu_ref(op, x, y), 1'b1);
		end
		for (i = 0; i < 9; i++) begin
			x = $random(seed);
			imm = $random(seed);
			op = imm_ops[i];
			if (op == alu_sll || op == alu_srl || op == alu_sra)
				imm = {1'b0, op[3], 5'b0, imm[4:0]}; // shamt, bit 30 for srai
			load_const(1, x);
			emit(enc_i(imm, 1, op[2:0], 3, op_imm));
			emit_store(3, alu_ref(op, x, {{20{imm[11]}}, imm}), 1'b1);
		end
		for (i = 0; i < 4; i++) begin
			x = $random(seed);
			mem[load_base + i] = byte_swap(x);
			emit(enc_i(12'((load_base + i) * 4), 0, 3'b010, 5, op_load));
			emit(enc_i(12'd1, 5, 3'b000, 6, op_imm));
			emit_store(6, x + 1, 1'b1);
		end
		for (i = 0; i < 2; i++) begin
			u = $random(seed);
			emit(enc_u(u, 8, op_lui));
			emit_store(8, {u, 12'b0}, 1'b1);
			p = pc_w * 4;
			emit(enc_u(u, 9, op_auipc));
			emit_store(9, p + {u, 12'b0}, 1'b1);
		end
		// branch operands and the marker value
		for (i = 0; i < 3; i++)
			emit(enc_i(bvals[i][11:0], 0, 3'b000, bregs[i], op_imm));
		emit(enc_i(marker[11:0], 0, 3'b000, 13, op_imm));
		for (i = 0; i < 18; i++) begin
			emit(enc_b(13'd8, bf3[i / 3], bregs[pr1[i % 3]], bregs[pr2[i % 3]]));
			emit_store(13, marker,
				!branch_ref(bf3[i / 3], bvals[pr1[i % 3]], bvals[pr2[i % 3]]));
		end
		p = pc_w * 4;
		emit(enc_j(21'd8, 5));
		emit_store(13, marker, 1'b0);
		emit_store(5, p + 4, 1'b1);
		p = pc_w * 4;
		emit(enc_u(20'h0, 6, op_auipc));
		emit(enc_i(12'd17, 6, 3'b000, 7, op_jalr)); // odd target, bit 0 cleared
		emit_store(13, marker, 1'b0);
		emit_store(13, marker, 1'b0);
		emit_store(7, p + 8, 1'b1);
		halt_addr = pc_w * 4;
		emit(32'h0000_007f); // undefined opcode
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model, compare and halt monitor
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			wait_left = -1;
		end else if (ready) begin
			ready <= 1'b0; // transfer completes at this edge
			if (we)
				mem[a[9:2]] = d;
		end else if (rd || we) begin
			if (wait_left < 0)
				wait_left = {$random(seed)} % 4;
			if (wait_left == 0) begin
				ready <= 1'b1;
				spo <= mem[a[9:2]];
				wait_left = -1;
			end else
				wait_left = wait_left - 1;
		end
	end

	always @(posedge clk) begin : compare_writes
		logic [31:0] ea;
		logic [31:0] ed;
		if (!rst && ready && we) begin
			checks++;
			assert (exp_addr.size() > 0) else begin
				errors++;
				$display("unexpected write of %h to address %h at %0t", d, a, $time);
			end
			if (exp_addr.size() > 0) begin
				ea = exp_addr.pop_front();
				ed = exp_data.pop_front();
				assert (a == ea) else begin
					errors++;
					$display("Mismatch at %0t: a expected %h got %h", $time, ea, a);
				end
				assert (d == byte_swap(ed)) else begin
					errors++;
					$display("Mismatch at %0t: d expected %h got %h", $time, byte_swap(ed), d);
				end
			end
		end
	end

	always @(posedge clk) begin
		if (halted) begin
			assert (!(rd || we)) else begin
				errors++;
				$display("bus request at %0t after the core reached its halt word", $time);
			end
		end
		if (!rst && ready && rd && a == halt_addr)
			halted = 1'b1;
	end

	// limit from program length, 5 phases of up to 4 wait cycles each
	initial begin
		wait (prog_done);
		#(limit_ns);
		$display("watchdog expired at %0t before the halt check finished", $time);
		$display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
			u_rv_core.u_core_assertions.fails);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ready = 1'b0;
		spo = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = {i[7:0], ~i[7:0], i[7:0], 8'h5a};
		build_program();
		limit_ns = longint'(pc_w) * 5 * 4 * 40 + (halt_watch + 40) * 40;
		prog_done = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		wait (halted);
		repeat (halt_watch) @(posedge clk);
		assert (exp_addr.size() == 0) else begin
			errors++;
			$display("%0d expected write(s) never happened", exp_addr.size());
		end
		$display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
			u_rv_core.u_core_assertions.fails);
		if (errors == 0 && u_rv_core.u_core_assertions.fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: project.f
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/core_fsm.sv
design/pc_unit.sv
design/reg_file.sv
design/alu.sv
design/imm_decode.sv
design/mem_port.sv
design/rv_core.sv
tb/core_assertions.sv
tb/tb_rv_core.sv
